//--- design/dma_ctrl_cfg.svh
// register map offsets, field widths and counter sizes of the DMA control block
`ifndef DMA_CTRL_CFG_SVH
`define DMA_CTRL_CFG_SVH

// descriptor field widths
`define DMA_PCIE_ADDR_W 64
`define DMA_AXI_ADDR_W  32
`define DMA_LEN_W       16
`define DMA_TAG_W       8

// packet counters, one per PCIe stream
`define DMA_CNT_W       32
`define DMA_CNT_NUM     4

// error pulse merging
`define DMA_ERR_SRC     3
`define DMA_ERR_CNT_W   4

// APB register map, byte addresses
`define APB_ADDR_W      16
`define REG_ENABLE      16'h0000
`define REG_RD_BASE     16'h0100
`define REG_WR_BASE     16'h0200
`define REG_CNT_BASE    16'h0400

// field offsets inside a channel window
`define OFS_PCIE_LO     8'h00
`define OFS_PCIE_HI     8'h04
`define OFS_AXI         8'h08
`define OFS_LEN         8'h10
`define OFS_TAG         8'h14
`define OFS_STATUS      8'h18

`define STATUS_VALID_BIT 31

`endif

//--- design/dma_ctrl_pkg.sv
// package with descriptor, status, stream beat and channel write types
`default_nettype none

`include "dma_ctrl_cfg.svh"

package dma_ctrl_pkg;

    // one DMA transfer request as the engine sees it
    typedef struct packed {
        logic [`DMA_PCIE_ADDR_W-1:0] pcie_addr;
        logic [`DMA_AXI_ADDR_W-1:0]  axi_addr;
        logic [`DMA_LEN_W-1:0]       len;
        logic [`DMA_TAG_W-1:0]       tag;
    } dma_desc_t;

    // completion status coming back from an engine
    typedef struct packed {
        logic [`DMA_TAG_W-1:0] tag;
        logic                  valid;
    } dma_status_t;

    // handshake bits of one AXI stream, payload not needed
    typedef struct packed {
        logic valid;
        logic ready;
        logic last;
    } stream_beat_t;

    typedef enum logic [2:0] {
        PCIE_LO,
        PCIE_HI,
        AXI,
        LEN,
        TAG
    } desc_field_e;

    // single field update from the register block
    typedef struct packed {
        logic        en;
        desc_field_e field;
        logic [31:0] data;
    } chan_wr_t;

endpackage

`default_nettype wire

//--- design/dma_ctrl_regs.sv
// APB register block: enable bit, channel field writes, status pop and readback mux
`default_nettype none

`include "dma_ctrl_cfg.svh"

module dma_ctrl_regs (
    input  wire                                    clk,
    input  wire                                    rst,
    input  wire                                    psel,
    input  wire                                    penable,
    input  wire                                    pwrite,
    input  wire [`APB_ADDR_W-1:0]                  paddr,
    input  wire [31:0]                             pwdata,
    output logic [31:0]                            prdata,
    output logic                                   pready,
    output logic                                   pslverr,
    output dma_ctrl_pkg::chan_wr_t                 rd_wr,
    output dma_ctrl_pkg::chan_wr_t                 wr_wr,
    input  wire                                    rd_busy,
    input  wire                                    wr_busy,
    input  wire dma_ctrl_pkg::dma_desc_t           rd_desc,
    input  wire dma_ctrl_pkg::dma_desc_t           wr_desc,
    input  wire dma_ctrl_pkg::dma_status_t         rd_status,
    input  wire dma_ctrl_pkg::dma_status_t         wr_status,
    output logic                                   rd_status_ready,
    output logic                                   wr_status_ready,
    input  wire [`DMA_CNT_NUM-1:0][`DMA_CNT_W-1:0] counts,
    output logic                                   dma_enable
);

    localparam int AW = `APB_ADDR_W;
    localparam int CNT_IDX_W = $clog2(`DMA_CNT_NUM);
    localparam logic [AW-1:0] ENABLE_ADDR = `REG_ENABLE;
    localparam logic [AW-1:0] RD_BASE = `REG_RD_BASE;
    localparam logic [AW-1:0] WR_BASE = `REG_WR_BASE;
    localparam logic [AW-1:0] CNT_BASE = `REG_CNT_BASE;

    logic                        wr_access;
    logic                        rd_access;
    logic [AW-1:0]               addr_w;
    logic [7:0]                  ofs;
    logic                        rd_sel;
    logic                        wr_sel;
    logic                        cnt_hit;
    logic [CNT_IDX_W-1:0]        cnt_idx;
    logic                        fld_hit;
    logic                        sts_hit;
    dma_ctrl_pkg::desc_field_e   fld;

    function automatic logic [31:0] field_read(dma_ctrl_pkg::dma_desc_t d,
                                               dma_ctrl_pkg::desc_field_e f);
        logic [31:0] v;
        v = '0;
        case (f)
            dma_ctrl_pkg::PCIE_LO: v = d.pcie_addr[31:0];
            dma_ctrl_pkg::PCIE_HI: v = d.pcie_addr[`DMA_PCIE_ADDR_W-1:32];
            dma_ctrl_pkg::AXI:     v[`DMA_AXI_ADDR_W-1:0] = d.axi_addr;
            dma_ctrl_pkg::LEN:     v[`DMA_LEN_W-1:0] = d.len;
            dma_ctrl_pkg::TAG:     v[`DMA_TAG_W-1:0] = d.tag;
            default:               v = '0;
        endcase
        return v;
    endfunction

    function automatic logic [31:0] status_read(dma_ctrl_pkg::dma_status_t s);
        logic [31:0] v;
        v = '0;
        v[`DMA_TAG_W-1:0] = s.tag;
        v[`STATUS_VALID_BIT] = s.valid;
        return v;
    endfunction

    // zero wait states, so the access phase is the whole transfer
    assign pready    = 1'b1;
    assign wr_access = psel && penable && pwrite;
    assign rd_access = psel && penable && !pwrite;

    assign addr_w  = {paddr[AW-1:2], 2'b00};
    assign ofs     = addr_w[7:0];
    assign rd_sel  = addr_w[AW-1:8] == RD_BASE[AW-1:8];
    assign wr_sel  = addr_w[AW-1:8] == WR_BASE[AW-1:8];
    assign cnt_hit = addr_w[AW-1:CNT_IDX_W+2] == CNT_BASE[AW-1:CNT_IDX_W+2];
    assign cnt_idx = addr_w[CNT_IDX_W+1:2];
    assign sts_hit = ofs == `OFS_STATUS;

    always_comb begin
        fld     = dma_ctrl_pkg::PCIE_LO;
        fld_hit = 1'b1;
        case (ofs)
            `OFS_PCIE_LO: fld = dma_ctrl_pkg::PCIE_LO;
            `OFS_PCIE_HI: fld = dma_ctrl_pkg::PCIE_HI;
            `OFS_AXI:     fld = dma_ctrl_pkg::AXI;
            `OFS_LEN:     fld = dma_ctrl_pkg::LEN;
            `OFS_TAG:     fld = dma_ctrl_pkg::TAG;
            default:      fld_hit = 1'b0;
        endcase
    end

    // a pending descriptor belongs to the engine
    always_comb begin
        rd_wr.en    = wr_access && rd_sel && fld_hit && !rd_busy;
        rd_wr.field = fld;
        rd_wr.data  = pwdata;
        wr_wr.en    = wr_access && wr_sel && fld_hit && !wr_busy;
        wr_wr.field = fld;
        wr_wr.data  = pwdata;
        pslverr     = wr_access && fld_hit && ((rd_sel && rd_busy) || (wr_sel && wr_busy));
    end

    // status pops only when an entry is really there
    assign rd_status_ready = rd_access && rd_sel && sts_hit && rd_status.valid;
    assign wr_status_ready = rd_access && wr_sel && sts_hit && wr_status.valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            dma_enable <= 1'b0;
        end else if (wr_access && addr_w == ENABLE_ADDR) begin
            dma_enable <= pwdata[0];
        end
    end

    always_comb begin
        prdata = '0;
        if (addr_w == ENABLE_ADDR) begin
            prdata[0] = dma_enable;
        end else if (rd_sel && fld_hit) begin
            prdata = field_read(rd_desc, fld);
        end else if (rd_sel && sts_hit) begin
            prdata = status_read(rd_status);
        end else if (wr_sel && fld_hit) begin
            prdata = field_read(wr_desc, fld);
        end else if (wr_sel && sts_hit) begin
            prdata = status_read(wr_status);
        end else if (cnt_hit) begin
            prdata = counts[cnt_idx];
        end
    end

    a_apb_enable_needs_sel: assert property (
        @(posedge clk) disable iff (rst) penable |-> psel
    ) else $error("APB penable without psel");

endmodule

`default_nettype wire

//--- design/dma_desc_channel.sv
// DMA descriptor channel: field registers and valid/ready launch of one descriptor
`default_nettype none

`include "dma_ctrl_cfg.svh"

module dma_desc_channel (
    input  wire                         clk,
    input  wire                         rst,
    input  wire dma_ctrl_pkg::chan_wr_t wr,
    output dma_ctrl_pkg::dma_desc_t     desc,
    output logic                        desc_valid,
    input  wire                         desc_ready
);

    logic launch;

    // writing the tag is what hands the descriptor to the engine
    assign launch = wr.en && (wr.field == dma_ctrl_pkg::TAG);

    always_ff @(posedge clk) begin
        if (wr.en) begin
            case (wr.field)
                dma_ctrl_pkg::PCIE_LO: begin
                    desc.pcie_addr[31:0] <= wr.data;
                end
                dma_ctrl_pkg::PCIE_HI: begin
                    desc.pcie_addr[`DMA_PCIE_ADDR_W-1:32] <= wr.data;
                end
                dma_ctrl_pkg::AXI: begin
                    desc.axi_addr <= wr.data[`DMA_AXI_ADDR_W-1:0];
                end
                dma_ctrl_pkg::LEN: begin
                    desc.len <= wr.data[`DMA_LEN_W-1:0];
                end
                dma_ctrl_pkg::TAG: begin
                    desc.tag <= wr.data[`DMA_TAG_W-1:0];
                end
                default: begin
                    desc <= desc;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            desc_valid <= 1'b0;
        end else if (launch) begin
            desc_valid <= 1'b1;
        end else if (desc_ready) begin
            desc_valid <= 1'b0;
        end
    end

    // register block must hold off updates while the engine owns the descriptor
    a_no_strobe_when_pending: assert property (
        @(posedge clk) disable iff (rst) wr.en |-> !desc_valid
    ) else $error("descriptor field written while pending");

    // back-pressure keeps the descriptor frozen
    a_hold_until_ready: assert property (
        @(posedge clk) disable iff (rst)
        desc_valid && !desc_ready |=> desc_valid && $stable(desc)
    ) else $error("descriptor changed before acceptance");

endmodule

`default_nettype wire

//--- design/err_pulse_merge.sv
// error pulse merger that counts pulses from several sources and replays them one per cycle
`default_nettype none

`include "dma_ctrl_cfg.svh"

module err_pulse_merge (
    input  wire                    clk,
    input  wire                    rst,
    input  wire [`DMA_ERR_SRC-1:0] pulse_in,
    output logic                   pulse_out
);

    localparam int SUM_W = `DMA_ERR_CNT_W + $clog2(`DMA_ERR_SRC + 1);
    localparam logic [SUM_W-1:0] CNT_MAX = {`DMA_ERR_CNT_W{1'b1}};

    logic [`DMA_ERR_CNT_W-1:0] count;
    logic [`DMA_ERR_CNT_W-1:0] count_next;
    logic [SUM_W-1:0]          sum;

    always_comb begin
        sum = SUM_W'(count);
        for (int i = 0; i < `DMA_ERR_SRC; i++) begin
            sum = sum + SUM_W'(pulse_in[i]);
        end
        // one pending event leaves per cycle
        if (count != '0) begin
            sum = sum - 1'b1;
        end
        if (sum > CNT_MAX) begin
            count_next = CNT_MAX[`DMA_ERR_CNT_W-1:0];
        end else begin
            count_next = sum[`DMA_ERR_CNT_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count     <= '0;
            pulse_out <= 1'b0;
        end else begin
            count     <= count_next;
            pulse_out <= (count != '0);
        end
    end

    // a drained count must not wrap around
    a_no_underflow: assert property (
        @(posedge clk) disable iff (rst)
        (count == '0) && (pulse_in == '0) |=> (count == '0)
    ) else $error("pending error count underflowed");

endmodule

`default_nettype wire

//--- design/pcie_dma_ctrl.sv
// top level of the PCIe DMA control plane: channels, counters, error mergers, registers
`default_nettype none

`include "dma_ctrl_cfg.svh"

module pcie_dma_ctrl (
    input  wire                            clk,
    input  wire                            rst,

    // APB slave
    input  wire                            psel,
    input  wire                            penable,
    input  wire                            pwrite,
    input  wire [`APB_ADDR_W-1:0]          paddr,
    input  wire [31:0]                     pwdata,
    output logic [31:0]                    prdata,
    output logic                           pready,
    output logic                           pslverr,

    // descriptors towards the DMA engines
    output dma_ctrl_pkg::dma_desc_t        rd_desc,
    output logic                           rd_desc_valid,
    input  wire                            rd_desc_ready,
    output dma_ctrl_pkg::dma_desc_t        wr_desc,
    output logic                           wr_desc_valid,
    input  wire                            wr_desc_ready,

    // completion status from the engines
    input  wire dma_ctrl_pkg::dma_status_t rd_status,
    output logic                           rd_status_ready,
    input  wire dma_ctrl_pkg::dma_status_t wr_status,
    output logic                           wr_status_ready,

    // stream monitors
    input  wire dma_ctrl_pkg::stream_beat_t rq_beat,
    input  wire dma_ctrl_pkg::stream_beat_t rc_beat,
    input  wire dma_ctrl_pkg::stream_beat_t cq_beat,
    input  wire dma_ctrl_pkg::stream_beat_t cc_beat,

    input  wire [`DMA_ERR_SRC-1:0]         err_cor,
    input  wire [`DMA_ERR_SRC-1:0]         err_uncor,
    output logic                           err_cor_pulse,
    output logic                           err_uncor_pulse,

    output logic                           irq,
    output logic                           dma_enable
);

    dma_ctrl_pkg::chan_wr_t                 rd_wr;
    dma_ctrl_pkg::chan_wr_t                 wr_wr;
    logic [`DMA_CNT_NUM-1:0][`DMA_CNT_W-1:0] counts;

    // interrupt stays up while any completion waits to be popped
    assign irq = rd_status.valid || wr_status.valid;

    dma_desc_channel u_rd_chan (
        .clk        (clk),
        .rst        (rst),
        .wr         (rd_wr),
        .desc       (rd_desc),
        .desc_valid (rd_desc_valid),
        .desc_ready (rd_desc_ready)
    );

    dma_desc_channel u_wr_chan (
        .clk        (clk),
        .rst        (rst),
        .wr         (wr_wr),
        .desc       (wr_desc),
        .desc_valid (wr_desc_valid),
        .desc_ready (wr_desc_ready)
    );

    tlp_counters u_counters (
        .clk     (clk),
        .rst     (rst),
        .rq_beat (rq_beat),
        .rc_beat (rc_beat),
        .cq_beat (cq_beat),
        .cc_beat (cc_beat),
        .counts  (counts)
    );

    err_pulse_merge u_cor_merge (
        .clk       (clk),
        .rst       (rst),
        .pulse_in  (err_cor),
        .pulse_out (err_cor_pulse)
    );

    err_pulse_merge u_uncor_merge (
        .clk       (clk),
        .rst       (rst),
        .pulse_in  (err_uncor),
        .pulse_out (err_uncor_pulse)
    );

    // busy of each channel is its descriptor valid
    dma_ctrl_regs u_regs (
        .clk             (clk),
        .rst             (rst),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .paddr           (paddr),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr),
        .rd_wr           (rd_wr),
        .wr_wr           (wr_wr),
        .rd_busy         (rd_desc_valid),
        .wr_busy         (wr_desc_valid),
        .rd_desc         (rd_desc),
        .wr_desc         (wr_desc),
        .rd_status       (rd_status),
        .wr_status       (wr_status),
        .rd_status_ready (rd_status_ready),
        .wr_status_ready (wr_status_ready),
        .counts          (counts),
        .dma_enable      (dma_enable)
    );

endmodule

`default_nettype wire

//--- design/tlp_counters.sv
// packet counters for the four PCIe streams, rq, rc, cq and cc
`default_nettype none

`include "dma_ctrl_cfg.svh"

module tlp_counters (
    input  wire                                     clk,
    input  wire                                     rst,
    input  wire dma_ctrl_pkg::stream_beat_t         rq_beat,
    input  wire dma_ctrl_pkg::stream_beat_t         rc_beat,
    input  wire dma_ctrl_pkg::stream_beat_t         cq_beat,
    input  wire dma_ctrl_pkg::stream_beat_t         cc_beat,
    output logic [`DMA_CNT_NUM-1:0][`DMA_CNT_W-1:0] counts
);

    dma_ctrl_pkg::stream_beat_t [`DMA_CNT_NUM-1:0] beats;
    logic [`DMA_CNT_NUM-1:0]                       pkt_end;

    // counter index order matches the register map
    assign beats[0] = rq_beat;
    assign beats[1] = rc_beat;
    assign beats[2] = cq_beat;
    assign beats[3] = cc_beat;

    always_comb begin
        for (int i = 0; i < `DMA_CNT_NUM; i++) begin
            pkt_end[i] = beats[i].valid && beats[i].ready && beats[i].last;
        end
    end

    // free running, wraps at the top
    always_ff @(posedge clk) begin
        if (rst) begin
            counts <= '0;
        end else begin
            for (int i = 0; i < `DMA_CNT_NUM; i++) begin
                if (pkt_end[i]) begin
                    counts[i] <= counts[i] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- pcie_dma_ctrl.f
+incdir+design
design/dma_ctrl_pkg.sv
design/dma_desc_channel.sv
design/tlp_counters.sv
design/err_pulse_merge.sv
design/dma_ctrl_regs.sv
design/pcie_dma_ctrl.sv
test/tb_pcie_dma_ctrl.sv

//--- test/tb_pcie_dma_ctrl.sv
// testbench for the DMA control block: APB op table, engine and status models, stream and error stimulus
`default_nettype none

`include "dma_ctrl_cfg.svh"

module tb_pcie_dma_ctrl;

    typedef enum logic [2:0] {OP_WR, OP_RD, OP_HOLD, OP_SYNC, OP_STREAM, OP_ERR} op_e;

    typedef struct packed {
        op_e         op;
        logic [15:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
        logic        exp_err;
    } row_t;

    localparam int NUM_ROWS    = 40;
    localparam int CYCLE_LIMIT = 20 * NUM_ROWS + 500;

    // hold rows stall the engines: data bit 0 read side, bit 1 write side
    localparam row_t ROWS [NUM_ROWS] = '{
        '{OP_WR,     16'h0000, 32'h0000_0001, 32'h0000_0000, 1'b0},
        '{OP_RD,     16'h0000, 32'h0000_0000, 32'h0000_0001, 1'b0},
        '{OP_HOLD,   16'h0000, 32'h0000_0003, 32'h0000_0000, 1'b0},
        '{OP_WR,     16'h0100, 32'h89ab_cdef, 32'h0000_0000, 1'b0},
        '{OP_WR,     16'h0104, 32'h0000_0012, 32'h0000_0000, 1'b0},
        '{OP_WR,     16'h0108, 32'h4000_1000, 32'h0000_0000, 1'b0},
        '{OP_WR,     16'h0110, 32'h0000_0200, 32'h0000_0000, 1'b0},
        '{OP_RD,     16'h0108, 32'h0000_0000, 32'h4000_1000, 1'b0},
        '{OP_WR,     16'h0114, 32'h0000_005a, 32'h0000_0000, 1'b0},
        '{OP_WR,     16'h0100, 32'hdead_beef, 32'h0000_0000, 1'b1},
        '{OP_WR,     16'h0110, 32'h0000_ffff, 32'h0000_0000, 1'b1},
        '{OP_RD,     16'h0100, 32'h0000_0000, 32'h89ab_cdef, 1'b0},
        '{OP_RD,     16'h0114, 32'h0000_0000, 32'h0000_005a, 1'b0},
        '{OP_WR,     16'h0200, 32'h1357_9bdf, 32'h0000_0000, 1'b0},
        '{OP_WR,     16'h0204, 32'h0000_0001, 32'h0000_0000, 1'b0},
        '{OP_WR,     16'h0208, 32'h2000_0040, 32'h0000_0000, 1'b0},
        '{OP_WR,     16'h0210, 32'h0000_0080, 32'h0000_0000, 1'b0},
        '{OP_WR,     16'h0214, 32'h0000_00a7, 32'h0000_0000, 1'b0},
        '{OP_WR,     16'h0214, 32'h0000_0033, 32'h0000_0000, 1'b1},
        '{OP_RD,     16'h0218, 32'h0000_0000, 32'h0000_0000, 1'b0},
        '{OP_RD,     16'h0204, 32'h0000_0000, 32'h0000_0001, 1'b0},
        '{OP_HOLD,   16'h0000, 32'h0000_0000, 32'h0000_0000, 1'b0},
        '{OP_SYNC,   16'h0000, 32'h0000_0000, 32'h0000_0000, 1'b0},
        '{OP_RD,     16'h0118, 32'h0000_0000, 32'h8000_005a, 1'b0},
        '{OP_RD,     16'h0118, 32'h0000_0000, 32'h0000_0000, 1'b0},
        '{OP_RD,     16'h0218, 32'h0000_0000, 32'h8000_00a7, 1'b0},
        '{OP_RD,     16'h0218, 32'h0000_0000, 32'h0000_0000, 1'b0},
        '{OP_WR,     16'h0114, 32'h0000_0066, 32'h0000_0000, 1'b0},
        '{OP_SYNC,   16'h0000, 32'h0000_0000, 32'h0000_0000, 1'b0},
        '{OP_RD,     16'h0118, 32'h0000_0000, 32'h8000_0066, 1'b0},
        '{OP_RD,     16'h0118, 32'h0000_0000, 32'h0000_0000, 1'b0},
        '{OP_STREAM, 16'h0000, 32'h0000_0005, 32'h0000_0000, 1'b0},
        '{OP_RD,     16'h0400, 32'h0000_0000, 32'h0000_0005, 1'b0},
        '{OP_RD,     16'h0404, 32'h0000_0000, 32'h0000_0005, 1'b0},
        '{OP_RD,     16'h0408, 32'h0000_0000, 32'h0000_0005, 1'b0},
        '{OP_RD,     16'h040c, 32'h0000_0000, 32'h0000_0005, 1'b0},
        '{OP_ERR,    16'h0000, 32'h0000_0004, 32'h0000_0000, 1'b0},
        '{OP_RD,     16'h0300, 32'h0000_0000, 32'h0000_0000, 1'b0},
        '{OP_WR,     16'h0000, 32'h0000_0000, 32'h0000_0000, 1'b0},
        '{OP_RD,     16'h0000, 32'h0000_0000, 32'h0000_0000, 1'b0}
    };

    // descriptors the engines must receive, in order
    localparam dma_ctrl_pkg::dma_desc_t RD_DESC_A =
        '{64'h0000_0012_89ab_cdef, 32'h4000_1000, 16'h0200, 8'h5a};
    localparam dma_ctrl_pkg::dma_desc_t RD_DESC_B =
        '{64'h0000_0012_89ab_cdef, 32'h4000_1000, 16'h0200, 8'h66};
    localparam dma_ctrl_pkg::dma_desc_t WR_DESC_A =
        '{64'h0000_0001_1357_9bdf, 32'h2000_0040, 16'h0080, 8'ha7};

    logic                       clk;
    logic                       rst;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`APB_ADDR_W-1:0]     paddr;
    logic [31:0]                pwdata;
    logic [31:0]                prdata;
    logic                       pready;
    logic                       pslverr;
    dma_ctrl_pkg::dma_desc_t    rd_desc;
    dma_ctrl_pkg::dma_desc_t    wr_desc;
    logic                       rd_desc_valid;
    logic                       rd_desc_ready;
    logic                       wr_desc_valid;
    logic                       wr_desc_ready;
    dma_ctrl_pkg::dma_status_t  rd_status;
    dma_ctrl_pkg::dma_status_t  wr_status;
    logic                       rd_status_ready;
    logic                       wr_status_ready;
    dma_ctrl_pkg::stream_beat_t rq_beat;
    dma_ctrl_pkg::stream_beat_t rc_beat;
    dma_ctrl_pkg::stream_beat_t cq_beat;
    dma_ctrl_pkg::stream_beat_t cc_beat;
    logic [`DMA_ERR_SRC-1:0]    err_cor;
    logic [`DMA_ERR_SRC-1:0]    err_uncor;
    logic                       err_cor_pulse;
    logic                       err_uncor_pulse;
    logic                       irq;
    logic                       dma_enable;

    integer                     seed = 32'hc9f4_7163;
    int                         cycles = 0;
    logic                       rd_hold = 1'b0;
    logic                       wr_hold = 1'b0;
    int                         rd_wait = -1;
    int                         wr_wait = -1;
    logic                       rd_popped = 1'b0;
    logic                       wr_popped = 1'b0;
    logic                       rd_hold_chk = 1'b0;
    logic                       wr_hold_chk = 1'b0;
    dma_ctrl_pkg::dma_desc_t    rd_held;
    dma_ctrl_pkg::dma_desc_t    wr_held;
    dma_ctrl_pkg::dma_desc_t    rd_exp [$];
    dma_ctrl_pkg::dma_desc_t    wr_exp [$];
    logic [`DMA_TAG_W-1:0]      rd_sq [$];
    logic [`DMA_TAG_W-1:0]      wr_sq [$];
    int                         cor_sent = 0;
    int                         cor_seen = 0;
    int                         uncor_sent = 0;
    int                         uncor_seen = 0;

    pcie_dma_ctrl u_pcie_dma_ctrl (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("Mismatch %s: got 'h%0h, expected 'h%0h", name, got, exp));
        end
    endtask

    // zero wait state transfer, responses sampled inside the access phase
    task automatic apb_access(input logic write, input logic [15:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #1;
        check_value("pready", pready, 1);
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_engines_idle();
        do begin
            @(negedge clk);
            #1;
        end while (rd_desc_valid || wr_desc_valid || rd_sq.size() != 0 || wr_sq.size() != 0);
    endtask

    // random beats until every stream has seen n packet ends
    task automatic drive_packets(input int n);
        int                         sent [4] = '{default: 0};
        logic [2:0]                 b;
        dma_ctrl_pkg::stream_beat_t beat [4];
        while (sent[0] < n || sent[1] < n || sent[2] < n || sent[3] < n) begin
            @(negedge clk);
            for (int i = 0; i < 4; i++) begin
                b = 3'($random(seed));
                if (sent[i] >= n) begin
                    b = 3'b000;
                end
                beat[i] = b;
                if (b == 3'b111) begin
                    sent[i]++;
                end
            end
            rq_beat = beat[0];
            rc_beat = beat[1];
            cq_beat = beat[2];
            cc_beat = beat[3];
        end
        @(negedge clk);
        rq_beat = '0;
        rc_beat = '0;
        cq_beat = '0;
        cc_beat = '0;
    endtask

    task automatic pulse_errors(input int n_cycles);
        logic [2:0] c;
        logic [2:0] u;
        repeat (n_cycles) begin
            @(negedge clk);
            c          = 3'($random(seed));
            u          = 3'($random(seed));
            err_cor    = c;
            err_uncor  = u;
            cor_sent   = cor_sent + $countones(c);
            uncor_sent = uncor_sent + $countones(u);
        end
        @(negedge clk);
        err_cor   = '0;
        err_uncor = '0;
        // output lags the inputs by two edges, then drains without gaps
        @(negedge clk);
        while (err_cor_pulse || err_uncor_pulse) begin
            @(negedge clk);
        end
        check_value("err_cor_pulse cycles", cor_seen, cor_sent);
        check_value("err_uncor_pulse cycles", uncor_seen, uncor_sent);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            stop_with_error("Timeout: the run went past its cycle limit without finishing");
        end
    end

    // monitor, values seen here are the ones held over the last cycle
    always @(posedge clk) begin
        if (!rst) begin
            check_value("irq", irq, rd_status.valid || wr_status.valid);
            if (rd_hold_chk) begin
                check_value("rd_desc_valid", rd_desc_valid, 1);
                check_value("rd_desc", rd_desc, rd_held);
            end
            if (wr_hold_chk) begin
                check_value("wr_desc_valid", wr_desc_valid, 1);
                check_value("wr_desc", wr_desc, wr_held);
            end
            if (rd_desc_valid && rd_desc_ready) begin
                if (rd_exp.size() == 0) begin
                    stop_with_error("read channel issued a descriptor that was never launched");
                end else begin
                    check_value("rd_desc", rd_desc, rd_exp.pop_front());
                    rd_sq.push_back(rd_desc.tag);
                end
            end
            if (wr_desc_valid && wr_desc_ready) begin
                if (wr_exp.size() == 0) begin
                    stop_with_error("write channel issued a descriptor that was never launched");
                end else begin
                    check_value("wr_desc", wr_desc, wr_exp.pop_front());
                    wr_sq.push_back(wr_desc.tag);
                end
            end
            rd_hold_chk = rd_desc_valid && !rd_desc_ready;
            wr_hold_chk = wr_desc_valid && !wr_desc_ready;
            rd_held     = rd_desc;
            wr_held     = wr_desc;
            if (rd_status_ready && rd_status.valid) begin
                rd_popped = 1'b1;
            end
            if (wr_status_ready && wr_status.valid) begin
                wr_popped = 1'b1;
            end
            if (err_cor_pulse) begin
                cor_seen++;
            end
            if (err_uncor_pulse) begin
                uncor_seen++;
            end
        end
    end

    // engine models: accept after 0 to 3 cycles, then report completion
    always @(negedge clk) begin
        if (!rst) begin
            if (rd_desc_ready) begin
                rd_desc_ready = 1'b0;
            end else if (rd_desc_valid && !rd_hold) begin
                if (rd_wait < 0) begin
                    rd_wait = $unsigned($random(seed)) % 4;
                end
                if (rd_wait == 0) begin
                    rd_desc_ready = 1'b1;
                end
                rd_wait = rd_wait - 1;
            end
            if (wr_desc_ready) begin
                wr_desc_ready = 1'b0;
            end else if (wr_desc_valid && !wr_hold) begin
                if (wr_wait < 0) begin
                    wr_wait = $unsigned($random(seed)) % 4;
                end
                if (wr_wait == 0) begin
                    wr_desc_ready = 1'b1;
                end
                wr_wait = wr_wait - 1;
            end
            if (rd_popped) begin
                rd_status = '0;
                rd_popped = 1'b0;
            end
            if (!rd_status.valid && rd_sq.size() != 0) begin
                rd_status.tag   = rd_sq.pop_front();
                rd_status.valid = 1'b1;
            end
            if (wr_popped) begin
                wr_status = '0;
                wr_popped = 1'b0;
            end
            if (!wr_status.valid && wr_sq.size() != 0) begin
                wr_status.tag   = wr_sq.pop_front();
                wr_status.valid = 1'b1;
            end
        end
    end

    initial begin : main
        logic [31:0] rdata;
        logic        err;
        rst           = 1'b1;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        rd_desc_ready = 1'b0;
        wr_desc_ready = 1'b0;
        rd_status     = '0;
        wr_status     = '0;
        rq_beat       = '0;
        rc_beat       = '0;
        cq_beat       = '0;
        cc_beat       = '0;
        err_cor       = '0;
        err_uncor     = '0;
        rd_exp.push_back(RD_DESC_A);
        rd_exp.push_back(RD_DESC_B);
        wr_exp.push_back(WR_DESC_A);
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("outputs after reset", {rd_desc_valid, wr_desc_valid, dma_enable,
                    err_cor_pulse, err_uncor_pulse, rd_status_ready, wr_status_ready}, 0);

        for (int i = 0; i < NUM_ROWS; i++) begin
            case (ROWS[i].op)
                OP_WR, OP_RD: begin
                    apb_access(ROWS[i].op == OP_WR, ROWS[i].addr, ROWS[i].data, rdata, err);
                    check_value($sformatf("pslverr at %h", ROWS[i].addr), err, ROWS[i].exp_err);
                    if (ROWS[i].op == OP_RD) begin
                        check_value($sformatf("prdata at %h", ROWS[i].addr), rdata, ROWS[i].exp);
                    end else if (ROWS[i].addr == `REG_ENABLE) begin
                        check_value("dma_enable", dma_enable, ROWS[i].data[0]);
                    end
                end
                OP_HOLD: begin
                    @(posedge clk);
                    rd_hold = ROWS[i].data[0];
                    wr_hold = ROWS[i].data[1];
                end
                OP_SYNC: begin
                    wait_engines_idle();
                end
                OP_STREAM: begin
                    drive_packets(ROWS[i].data);
                end
                default: begin
                    pulse_errors(ROWS[i].data);
                end
            endcase
        end

        check_value("read descriptors never issued", rd_exp.size(), 0);
        check_value("write descriptors never issued", wr_exp.size(), 0);
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
